//--- design/csr_defines.svh
// CSR writeback widths and constants
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath widths
`define XLEN            64
`define CSR_ADDR_SIZE   12

// machine-mode CSR addresses
`define CSR_MSCRATCH    12'h340
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MINSTRET    12'hB02

// funct12 of system instructions, carried in csr_addr
`define SYS_ECALL       12'h000
`define SYS_MRET        12'h302

// trap cause codes
`define CAUSE_ECALL_M   64'd11

`endif

//--- design/csr_pkg.sv
// CSR writeback shared types
`include "csr_defines.svh"

package csr_pkg;

    // data word, CSR address, register index
    typedef logic [`XLEN-1:0]          bus64_t;
    typedef logic [`CSR_ADDR_SIZE-1:0] csr_addr_t;
    typedef logic [4:0]                reg_addr_t;

    // instruction class as seen at writeback
    typedef enum logic [3:0] {
        ALU,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        URET,
        SRET,
        MRET,
        WFI,
        SFENCE_VMA,
        MRTS
    } instr_type_t;

    // command toward the CSR file
    typedef enum logic [2:0] {
        CSR_CMD_NOPE,
        CSR_CMD_READ,
        CSR_CMD_WRITE,
        CSR_CMD_SET,
        CSR_CMD_CLEAR,
        CSR_CMD_SYS
    } csr_cmd_t;

    typedef struct packed {
        logic   valid;
        bus64_t cause;
        // faulting address or value for mtval
        bus64_t origin;
    } exception_t;

    // execute to writeback pipeline payload
    typedef struct packed {
        logic        valid;
        bus64_t      pc;
        instr_type_t instr_type;
        reg_addr_t   rs1;
        reg_addr_t   rd;
        csr_addr_t   csr_addr;
        bus64_t      result;
        exception_t  ex;
    } exe_wb_instr_t;

    typedef struct packed {
        csr_addr_t csr_rw_addr;
        csr_cmd_t  csr_rw_cmd;
        bus64_t    csr_rw_data;
        logic      csr_exception;
        logic      csr_retire;
        bus64_t    csr_xcpt_cause;
        bus64_t    csr_pc;
    } req_cpu_csr_t;

    typedef struct packed {
        bus64_t csr_rw_rdata;
        logic   redirect_valid;
        bus64_t redirect_pc;
    } resp_csr_cpu_t;

    typedef struct packed {
        reg_addr_t rd;
        bus64_t    data;
    } wb_result_t;

endpackage

//--- design/wb_stage.sv
// Writeback pipeline stage
`timescale 1ns/10ps

module wb_stage (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // execute side
    input  logic                   exe_valid_i,
    input  csr_pkg::exe_wb_instr_t exe_instr_i,
    output logic                   exe_ready_o,
    // writeback side
    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output csr_pkg::wb_result_t    wb_result_o,
    // CSR path
    input  csr_pkg::bus64_t        csr_rdata_i,
    input  logic                   csr_ena_i,
    output csr_pkg::exe_wb_instr_t wb_instr_o,
    output logic                   wb_xcpt_o
);

    logic                   valid_q;
    csr_pkg::exe_wb_instr_t instr_q;
    logic                   accept;
    logic                   fire;

    assign fire        = valid_q & wb_ready_i;
    // free slot, or the held entry leaves this cycle
    assign exe_ready_o = ~valid_q | wb_ready_i;
    assign accept      = exe_valid_i & exe_ready_o;
    assign wb_valid_o  = valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= exe_instr_i;
        end
    end

    // commit only in the firing cycle
    always_comb begin
        wb_instr_o       = instr_q;
        wb_instr_o.valid = fire;
    end

    assign wb_xcpt_o = fire & instr_q.ex.valid;

    // result mux by instruction class
    always_comb begin
        wb_result_o.rd   = instr_q.rd;
        wb_result_o.data = instr_q.result;
        if (instr_q.ex.valid) begin
            wb_result_o.rd   = '0;
            wb_result_o.data = '0;
        end else begin
            case (instr_q.instr_type)
                csr_pkg::CSRRW, csr_pkg::CSRRS, csr_pkg::CSRRC,
                csr_pkg::CSRRWI, csr_pkg::CSRRSI, csr_pkg::CSRRCI: begin
                    // old CSR value, only valid once the request is live
                    wb_result_o.data = csr_ena_i ? csr_rdata_i : '0;
                end
                csr_pkg::ECALL, csr_pkg::EBREAK, csr_pkg::URET, csr_pkg::SRET,
                csr_pkg::MRET, csr_pkg::WFI, csr_pkg::SFENCE_VMA, csr_pkg::MRTS: begin
                    wb_result_o.rd   = '0;
                    wb_result_o.data = '0;
                end
                default: begin
                    wb_result_o.data = instr_q.result;
                end
            endcase
        end
    end

endmodule

//--- design/csr_interface.sv
// Writeback to CSR request decode
`timescale 1ns/10ps

module csr_interface (
    input  logic                   wb_xcpt_i,
    input  csr_pkg::exe_wb_instr_t exe_to_wb_wb_i,
    output csr_pkg::req_cpu_csr_t  req_cpu_csr_o,
    output logic                   wb_csr_ena_int_o
);

    logic               csr_ena;
    csr_pkg::csr_cmd_t  csr_cmd;
    csr_pkg::bus64_t    csr_data;
    csr_pkg::bus64_t    zimm;
    logic               rs1_zero;

    // immediate forms carry zimm in the rs1 field
    assign zimm     = csr_pkg::bus64_t'(exe_to_wb_wb_i.rs1);
    assign rs1_zero = (exe_to_wb_wb_i.rs1 == '0);

    always_comb begin
        csr_ena  = 1'b0;
        csr_cmd  = csr_pkg::CSR_CMD_NOPE;
        csr_data = '0;
        if (exe_to_wb_wb_i.valid) begin
            case (exe_to_wb_wb_i.instr_type)
                csr_pkg::CSRRW: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = csr_pkg::CSR_CMD_WRITE;
                    csr_data = exe_to_wb_wb_i.result;
                end
                csr_pkg::CSRRWI: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = csr_pkg::CSR_CMD_WRITE;
                    csr_data = zimm;
                end
                // set/clear with x0 or zero zimm only reads
                csr_pkg::CSRRS: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = rs1_zero ? csr_pkg::CSR_CMD_READ : csr_pkg::CSR_CMD_SET;
                    csr_data = exe_to_wb_wb_i.result;
                end
                csr_pkg::CSRRSI: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = rs1_zero ? csr_pkg::CSR_CMD_READ : csr_pkg::CSR_CMD_SET;
                    csr_data = zimm;
                end
                csr_pkg::CSRRC: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = rs1_zero ? csr_pkg::CSR_CMD_READ : csr_pkg::CSR_CMD_CLEAR;
                    csr_data = exe_to_wb_wb_i.result;
                end
                csr_pkg::CSRRCI: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = rs1_zero ? csr_pkg::CSR_CMD_READ : csr_pkg::CSR_CMD_CLEAR;
                    csr_data = zimm;
                end
                csr_pkg::ECALL, csr_pkg::EBREAK, csr_pkg::URET, csr_pkg::SRET,
                csr_pkg::MRET, csr_pkg::WFI, csr_pkg::SFENCE_VMA, csr_pkg::MRTS: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = csr_pkg::CSR_CMD_SYS;
                    csr_data = '0;
                end
                default: begin
                    csr_ena = 1'b0;
                end
            endcase
        end
    end

    assign req_cpu_csr_o.csr_rw_addr = csr_ena ? exe_to_wb_wb_i.csr_addr : '0;
    assign req_cpu_csr_o.csr_rw_cmd  = csr_ena ? csr_cmd : csr_pkg::CSR_CMD_NOPE;
    // no CSR access, so pass the fault origin along for mtval
    assign req_cpu_csr_o.csr_rw_data = csr_ena ? csr_data : exe_to_wb_wb_i.ex.origin;

    assign req_cpu_csr_o.csr_exception  = wb_xcpt_i;
    assign req_cpu_csr_o.csr_retire     = exe_to_wb_wb_i.valid & ~wb_xcpt_i;
    assign req_cpu_csr_o.csr_xcpt_cause = exe_to_wb_wb_i.ex.cause;
    assign req_cpu_csr_o.csr_pc         = exe_to_wb_wb_i.pc;

    assign wb_csr_ena_int_o = csr_ena;

endmodule

//--- design/csr_regfile.sv
// Machine-mode CSR file
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_regfile (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  csr_pkg::req_cpu_csr_t  req_cpu_csr_i,
    output csr_pkg::resp_csr_cpu_t resp_csr_cpu_o
);

    csr_pkg::bus64_t mscratch_q;
    csr_pkg::bus64_t mtvec_q;
    csr_pkg::bus64_t mepc_q;
    csr_pkg::bus64_t mcause_q;
    csr_pkg::bus64_t mtval_q;
    csr_pkg::bus64_t minstret_q;

    csr_pkg::bus64_t rdata;
    csr_pkg::bus64_t wdata;
    logic            is_sys;
    logic            is_ecall;
    logic            is_mret;
    logic            trap;
    logic            do_write;

    // combinational read where unknown addresses give zero
    always_comb begin
        case (req_cpu_csr_i.csr_rw_addr)
            `CSR_MSCRATCH: rdata = mscratch_q;
            `CSR_MTVEC:    rdata = mtvec_q;
            `CSR_MEPC:     rdata = mepc_q;
            `CSR_MCAUSE:   rdata = mcause_q;
            `CSR_MTVAL:    rdata = mtval_q;
            `CSR_MINSTRET: rdata = minstret_q;
            default:       rdata = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (req_cpu_csr_i.csr_rw_cmd)
            csr_pkg::CSR_CMD_WRITE: wdata = req_cpu_csr_i.csr_rw_data;
            csr_pkg::CSR_CMD_SET:   wdata = rdata | req_cpu_csr_i.csr_rw_data;
            csr_pkg::CSR_CMD_CLEAR: wdata = rdata & ~req_cpu_csr_i.csr_rw_data;
            default:                wdata = rdata;
        endcase
    end

    assign is_sys   = (req_cpu_csr_i.csr_rw_cmd == csr_pkg::CSR_CMD_SYS);
    assign is_ecall = is_sys & (req_cpu_csr_i.csr_rw_addr == `SYS_ECALL);
    assign is_mret  = is_sys & (req_cpu_csr_i.csr_rw_addr == `SYS_MRET)
                      & ~req_cpu_csr_i.csr_exception;
    assign trap     = req_cpu_csr_i.csr_exception | is_ecall;

    // an excepting instruction leaves the CSRs alone apart from trap state
    always_comb begin
        case (req_cpu_csr_i.csr_rw_cmd)
            csr_pkg::CSR_CMD_WRITE,
            csr_pkg::CSR_CMD_SET,
            csr_pkg::CSR_CMD_CLEAR: do_write = ~req_cpu_csr_i.csr_exception;
            default:                do_write = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (trap) begin
            mepc_q   <= req_cpu_csr_i.csr_pc;
            // ecall reports its own cause
            mcause_q <= req_cpu_csr_i.csr_exception ? req_cpu_csr_i.csr_xcpt_cause
                                                    : `CAUSE_ECALL_M;
            mtval_q  <= req_cpu_csr_i.csr_rw_data;
        end else if (do_write) begin
            case (req_cpu_csr_i.csr_rw_addr)
                `CSR_MSCRATCH: mscratch_q <= wdata;
                `CSR_MTVEC:    mtvec_q    <= wdata;
                `CSR_MEPC:     mepc_q     <= wdata;
                `CSR_MCAUSE:   mcause_q   <= wdata;
                `CSR_MTVAL:    mtval_q    <= wdata;
                // minstret is read-only here
                default: begin
                    mscratch_q <= mscratch_q;
                end
            endcase
        end
    end

    // retired instruction counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            minstret_q <= '0;
        end else if (req_cpu_csr_i.csr_retire) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    assign resp_csr_cpu_o.csr_rw_rdata   = rdata;
    assign resp_csr_cpu_o.redirect_valid = trap | is_mret;

    always_comb begin
        if (trap) begin
            resp_csr_cpu_o.redirect_pc = mtvec_q;
        end else if (is_mret) begin
            resp_csr_cpu_o.redirect_pc = mepc_q;
        end else begin
            resp_csr_cpu_o.redirect_pc = '0;
        end
    end

endmodule

//--- design/csr_wb_top.sv
// Writeback stage with CSR file
`timescale 1ns/10ps

module csr_wb_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   exe_valid_i,
    input  csr_pkg::exe_wb_instr_t exe_instr_i,
    output logic                   exe_ready_o,
    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output csr_pkg::wb_result_t    wb_result_o,
    output logic                   redirect_valid_o,
    output csr_pkg::bus64_t        redirect_pc_o
);

    csr_pkg::exe_wb_instr_t wb_instr;
    logic                   wb_xcpt;
    logic                   csr_ena;
    csr_pkg::req_cpu_csr_t  csr_req;
    csr_pkg::resp_csr_cpu_t csr_resp;

    wb_stage u_wb_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .exe_valid_i (exe_valid_i),
        .exe_instr_i (exe_instr_i),
        .exe_ready_o (exe_ready_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_result_o (wb_result_o),
        .csr_rdata_i (csr_resp.csr_rw_rdata),
        .csr_ena_i   (csr_ena),
        .wb_instr_o  (wb_instr),
        .wb_xcpt_o   (wb_xcpt)
    );

    csr_interface u_csr_interface (
        .wb_xcpt_i        (wb_xcpt),
        .exe_to_wb_wb_i   (wb_instr),
        .req_cpu_csr_o    (csr_req),
        .wb_csr_ena_int_o (csr_ena)
    );

    csr_regfile u_csr_regfile (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_cpu_csr_i  (csr_req),
        .resp_csr_cpu_o (csr_resp)
    );

    assign redirect_valid_o = csr_resp.redirect_valid;
    assign redirect_pc_o    = csr_resp.redirect_pc;

endmodule

//--- tb/tb_csr_wb.sv
// Testbench for the CSR writeback subsystem
`timescale 1ns/10ps
`include "csr_defines.svh"

module tb_csr_wb;

    localparam int unsigned MIN_VECTORS = 30;
    localparam string       STIM_FILE   = "tb/csr_stim.txt";

    // one instruction with its expected writeback
    typedef struct packed {
        csr_pkg::exe_wb_instr_t instr;
        csr_pkg::wb_result_t    exp_wb;
        logic                   exp_redir_valid;
        csr_pkg::bus64_t        exp_redir_pc;
        logic [3:0]             stall;
    } vector_t;

    logic                   clk_i;
    logic                   rst_i;
    logic                   exe_valid_i;
    csr_pkg::exe_wb_instr_t exe_instr_i;
    logic                   exe_ready_o;
    logic                   wb_valid_o;
    logic                   wb_ready_i;
    csr_pkg::wb_result_t    wb_result_o;
    logic                   redirect_valid_o;
    csr_pkg::bus64_t        redirect_pc_o;

    vector_t     vectors[$];
    int unsigned error_count;
    int unsigned check_count;
    int unsigned cur_vector;
    logic        loaded;

    csr_wb_top uut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .exe_valid_i      (exe_valid_i),
        .exe_instr_i      (exe_instr_i),
        .exe_ready_o      (exe_ready_o),
        .wb_valid_o       (wb_valid_o),
        .wb_ready_i       (wb_ready_i),
        .wb_result_o      (wb_result_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic check(input string name, input logic [`XLEN-1:0] expected,
                         input logic [`XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h (vector %0d)",
                     $time, name, expected, actual, cur_vector);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [63:0] f [14];
        vector_t     v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            error_count++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n != 14) begin
                $display("stimulus line has %0d fields instead of 14: %s", n, line);
                error_count++;
                continue;
            end
            v = '0;
            v.instr.valid      = 1'b1;
            v.instr.instr_type = csr_pkg::instr_type_t'(f[0][3:0]);
            v.instr.pc         = f[1];
            v.instr.rs1        = f[2][4:0];
            v.instr.rd         = f[3][4:0];
            v.instr.csr_addr   = f[4][11:0];
            v.instr.result     = f[5];
            v.instr.ex.valid   = f[6][0];
            v.instr.ex.cause   = f[7];
            v.instr.ex.origin  = f[8];
            v.exp_wb.rd        = f[9][4:0];
            v.exp_wb.data      = f[10];
            v.exp_redir_valid  = f[11][0];
            v.exp_redir_pc     = f[12];
            v.stall            = f[13][3:0];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() < MIN_VECTORS) begin
            $display("stimulus file is short: %0d vectors, at least %0d needed",
                     vectors.size(), MIN_VECTORS);
            error_count++;
        end
    endtask

    task automatic run_vector(input vector_t v);
        int unsigned        hold;
        csr_pkg::reg_addr_t held_rd;
        csr_pkg::bus64_t    held_data;
        hold        = v.stall + ($urandom % 4);
        exe_instr_i = v.instr;
        exe_valid_i = 1'b1;
        wb_ready_i  = 1'b0;
        do begin
            @(negedge clk_i);
        end while (!exe_ready_o);
        @(posedge clk_i);
        #1;
        exe_valid_i = 1'b0;
        exe_instr_i = '0;
        held_rd     = wb_result_o.rd;
        held_data   = wb_result_o.data;
        // the entry must sit still under back-pressure
        repeat (hold) begin
            @(negedge clk_i);
            check("wb_valid_o while stalled", 1'b1, wb_valid_o);
            check("exe_ready_o while stalled", 1'b0, exe_ready_o);
            check("redirect_valid_o while stalled", 1'b0, redirect_valid_o);
            check("wb_result_o.rd while stalled", held_rd, wb_result_o.rd);
            check("wb_result_o.data while stalled", held_data, wb_result_o.data);
            @(posedge clk_i);
            #1;
        end
        wb_ready_i = 1'b1;
        do begin
            @(negedge clk_i);
        end while (!wb_valid_o);
        check("wb_result_o.rd", v.exp_wb.rd, wb_result_o.rd);
        check("wb_result_o.data", v.exp_wb.data, wb_result_o.data);
        check("redirect_valid_o", v.exp_redir_valid, redirect_valid_o);
        if (v.exp_redir_valid) begin
            check("redirect_pc_o", v.exp_redir_pc, redirect_pc_o);
        end
        @(posedge clk_i);
        #1;
        wb_ready_i = 1'b0;
        // one writeback per instruction
        check("wb_valid_o after writeback", 1'b0, wb_valid_o);
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        exe_valid_i = 1'b0;
        exe_instr_i = '0;
        wb_ready_i  = 1'b0;
        error_count = 0;
        check_count = 0;
        cur_vector  = 0;
        loaded      = 1'b0;
        void'($urandom(32'h6a51268b));
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        check("wb_valid_o after reset", 1'b0, wb_valid_o);
        check("redirect_valid_o after reset", 1'b0, redirect_valid_o);
        check("exe_ready_o after reset", 1'b1, exe_ready_o);
        @(posedge clk_i);
        #1;
        foreach (vectors[i]) begin
            cur_vector = i;
            run_vector(vectors[i]);
        end
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // about 8 cycles per vector plus reset and slack
    initial begin : watchdog
        int unsigned limit;
        wait (loaded === 1'b1);
        limit = vectors.size() * 8 + 50;
        repeat (limit) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("test failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/csr_pkg.sv
design/wb_stage.sv
design/csr_interface.sv
design/csr_regfile.sv
design/csr_wb_top.sv
tb/tb_csr_wb.sv

//--- Makefile
# Verilator build and run for the CSR writeback testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_wb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed, see $(LOG)"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/csr_stim.txt
# type pc rs1 rd csr result ex_valid ex_cause ex_origin exp_rd exp_data exp_redir exp_redir_pc stall
# all hex; type 0 ALU 1 CSRRW 2 CSRRS 3 CSRRC 4 CSRRWI 5 CSRRSI 6 CSRRCI 7 ECALL b MRET c WFI
1 1000 01 05 340 1122334455667788 0 0 0 05 0 0 0 1
2 1004 00 06 340 ffff 0 0 0 06 1122334455667788 0 0 0
2 1008 00 07 340 0 0 0 0 07 1122334455667788 0 0 2
1 100c 02 08 305 80000000 0 0 0 08 0 0 0 0
2 1010 03 09 305 f0 0 0 0 09 80000000 0 0 1
3 1014 04 0a 305 30 0 0 0 0a 800000f0 0 0 0
5 1018 1f 0b 305 0 0 0 0 0b 800000c0 0 0 2
6 101c 05 0c 305 0 0 0 0 0c 800000df 0 0 0
6 1020 1a 0d 305 0 0 0 0 0d 800000da 0 0 1
2 1024 00 0e 305 0 0 0 0 0e 800000c0 0 0 0
4 1028 15 0f 340 0 0 0 0 0f 1122334455667788 0 0 0
0 102c 00 03 000 deadbeefcafef00d 0 0 0 03 deadbeefcafef00d 0 0 2
0 1030 00 04 000 0123456789abcdef 0 0 0 04 0123456789abcdef 0 0 0
2 1034 00 10 b02 0 0 0 0 10 d 0 0 1
0 2040 00 09 000 99 1 5 bad00008 00 0 1 800000c0 2
2 1038 00 11 341 0 0 0 0 11 2040 0 0 0
2 103c 00 12 342 0 0 0 0 12 5 0 0 1
2 1040 00 13 343 0 0 0 0 13 bad00008 0 0 0
2 1044 00 14 b02 0 0 0 0 14 11 0 0 0
7 3000 00 01 000 0 0 0 0 00 0 1 800000c0 1
2 1048 00 15 342 0 0 0 0 15 b 0 0 0
2 104c 00 16 341 0 0 0 0 16 3000 0 0 2
b 800000c0 00 00 302 0 0 0 0 00 0 1 3000 0
c 3004 00 02 105 0 0 0 0 00 0 0 0 1
1 3008 05 17 343 77 0 0 0 17 0 0 0 0
2 300c 00 18 343 0 0 0 0 18 77 0 0 0
2 3010 00 19 7c0 0 0 0 0 19 0 0 0 2
1 3014 06 1a b02 1234 0 0 0 1a 1a 0 0 0
2 3018 00 1b b02 0 0 0 0 1b 1b 0 0 1
2 301c 00 1c 340 0 0 0 0 1c 15 0 0 0
